// ==== verilog.f ====
+incdir+verification
src/gat_pkg.sv
src/weight_mem.sv
src/feat_rx.sv
src/wh_mult.sv
src/attn_coef.sv
src/coef_tx.sv
src/gat_core.sv
verification/tb_gat_core.sv

// ==== Makefile ====
TOP := tb_gat_core

.PHONY: sim lint clean

sim:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module gat_core

clean:
	rm -rf obj_dir

// ==== verification/tb_gat_tasks.svh ====
// Testbench tasks for weight load, node send and score receive
// Called at the sample point 1 ns after a rising edge, and return there

`ifndef TB_GAT_TASKS_SVH
`define TB_GAT_TASKS_SVH

task automatic write_weight(input int addr, input int value);
  logic signed [DATA_W-1:0] v;
  v = value[DATA_W-1:0];
  ref_wgt[addr] = int'(v);
  wgt_wr_en   = 1'b1;
  wgt_wr_addr = WGT_ADDR_W'(addr);
  wgt_wr_data = DATA_W'(value);
  @(posedge clk);
  #1;
  wgt_wr_en = 1'b0;
endtask

// Four-phase send of one node as the sender
task automatic send_node(input feat_vec_t h, input logic src);
  int wait_cnt;
  in_feat  = h;
  in_src   = src;
  in_req   = 1'b1;
  wait_cnt = 0;
  while (!in_ack) begin
    @(posedge clk);
    #1;
    wait_cnt++;
    if (wait_cnt >= TIMEOUT_CYCLES) begin
      abort_on_timeout("in_ack to rise");
    end
  end
  ack_cycle = cycle_cnt;
  if (wait_cnt > max_ack_wait) begin
    max_ack_wait = wait_cnt;
  end
  in_req   = 1'b0;
  wait_cnt = 0;
  while (in_ack) begin
    @(posedge clk);
    #1;
    wait_cnt++;
    if (wait_cnt >= TIMEOUT_CYCLES) begin
      abort_on_timeout("in_ack to fall");
    end
  end
endtask

// Four-phase receive of one score with ack held off by ack_delay cycles
task automatic recv_score(input int ack_delay);
  int   wait_cnt;
  int   exp_coef;
  logic exp_src;
  wait_cnt = 0;
  while (!out_req) begin
    @(posedge clk);
    #1;
    wait_cnt++;
    if (wait_cnt >= TIMEOUT_CYCLES) begin
      abort_on_timeout("out_req to rise");
    end
  end
  req_cycle = cycle_cnt;
  exp_coef  = exp_coef_q.pop_front();
  exp_src   = exp_src_q.pop_front();
  if (out_coef !== 32'(exp_coef)) begin
    err_count++;
    $display("Fail out_coef expected %h got %h", 32'(exp_coef), out_coef);
  end
  if (out_src !== exp_src) begin
    err_count++;
    $display("Fail out_src expected %h got %h", exp_src, out_src);
  end
  repeat (ack_delay) begin
    @(posedge clk);
    #1;
  end
  out_ack  = 1'b1;
  wait_cnt = 0;
  while (out_req) begin
    @(posedge clk);
    #1;
    wait_cnt++;
    if (wait_cnt >= TIMEOUT_CYCLES) begin
      abort_on_timeout("out_req to fall");
    end
  end
  out_ack = 1'b0;
endtask

`endif

// ==== verification/tb_gat_core.sv ====
`timescale 1ns/1ps
// Testbench top for the attention core
// Clock, reset, DUT, reference model and directed tests

module tb_gat_core
  import gat_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;

  logic                  clk;
  logic                  rst_n;
  logic                  wgt_wr_en;
  logic [WGT_ADDR_W-1:0] wgt_wr_addr;
  logic [DATA_W-1:0]     wgt_wr_data;
  logic                  in_req;
  feat_vec_t             in_feat;
  logic                  in_src;
  logic                  in_ack;
  logic                  out_req;
  logic [COEF_W-1:0]     out_coef;
  logic                  out_src;
  logic                  out_ack;

  int          err_count;
  int          timeout_count;
  int          cycle_cnt = 0;
  int          ack_cycle;
  int          req_cycle;
  int          max_ack_wait;
  logic [15:0] lfsr_state;

  // Reference model state
  int          ref_wgt [WGT_DEPTH];
  int          ref_src_score;

  feat_vec_t   node_feat_q [$];
  logic        node_src_q [$];
  int          exp_coef_q [$];
  logic        exp_src_q [$];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  gat_core dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_wr_en   (wgt_wr_en),
    .wgt_wr_addr (wgt_wr_addr),
    .wgt_wr_data (wgt_wr_data),
    .in_req      (in_req),
    .in_feat     (in_feat),
    .in_src      (in_src),
    .in_ack      (in_ack),
    .out_req     (out_req),
    .out_coef    (out_coef),
    .out_src     (out_src),
    .out_ack     (out_ack)
  );

  `include "tb_gat_tasks.svh"

  // ====================
  // Galois LFSR x^16+x^14+x^13+x^11+1 as the random source
  function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // ====================
  // Reference model
  function automatic int ref_score(input feat_vec_t h, input logic src);
    int hv;
    int wh_k;
    int s_dot;
    int n_dot;
    int sum;
    s_dot = 0;
    n_dot = 0;
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      wh_k = 0;
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        hv   = int'($signed(h[i]));
        wh_k = wh_k + hv * ref_wgt[k*NUM_FEAT_IN+i];
      end
      s_dot = s_dot + ref_wgt[A_SRC_BASE+k] * wh_k;
      n_dot = n_dot + ref_wgt[A_NBR_BASE+k] * wh_k;
    end
    if (src) begin
      ref_src_score = s_dot;
    end
    sum = ref_src_score + n_dot;
    // LeakyReLU
    if (sum < 0) begin
      sum = sum >>> LRELU_SHIFT;
    end
    return sum;
  endfunction

  task automatic add_node(input feat_vec_t h, input logic src);
    node_feat_q.push_back(h);
    node_src_q.push_back(src);
    exp_coef_q.push_back(ref_score(h, src));
    exp_src_q.push_back(src);
  endtask

  task automatic abort_on_timeout(input string what);
    timeout_count++;
    $display("Timed out while waiting for %s", what);
    $display("Errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
    $display("Simulation FAILED");
    $finish;
  endtask

  // Sender and receiver run side by side
  task automatic run_nodes(input int delay_bits);
    int n;
    n = node_feat_q.size();
    fork
      begin
        while (node_feat_q.size() > 0) begin
          send_node(node_feat_q.pop_front(), node_src_q.pop_front());
        end
      end
      begin
        for (int r = 0; r < n; r++) begin
          recv_score(int'(rand_bits(delay_bits)));
        end
      end
    join
  endtask

  task automatic load_identity_w();
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        write_weight(k*NUM_FEAT_IN+i, (k == i) ? 1 : 0);
      end
    end
  endtask

  // ====================
  // Directed tests
  task automatic reset_state_scores();
    if (in_ack !== 1'b0) begin
      err_count++;
      $display("Fail in_ack expected %h got %h", 1'b0, in_ack);
    end
    if (out_req !== 1'b0) begin
      err_count++;
      $display("Fail out_req expected %h got %h", 1'b0, out_req);
    end
    add_node(feat_vec_t'(rand_bits(32)), 1'b1);
    run_nodes(0);
    if (req_cycle - ack_cycle != 4) begin
      err_count++;
      $display("Fail out_req delay after in_ack expected %h got %h", 4, req_cycle - ack_cycle);
    end
  endtask

  task automatic identity_scores();
    load_identity_w();
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      write_weight(A_SRC_BASE + k, k + 1);
      write_weight(A_NBR_BASE + k, 2);
    end
    add_node({8'd4, 8'd3, 8'd2, 8'd1}, 1'b1);
    add_node({8'd1, 8'd0, 8'd5, 8'd2}, 1'b0);
    add_node({8'd7, 8'd1, 8'd1, 8'd3}, 1'b0);
    run_nodes(0);
  endtask

  // Negative a_src outweighs the neighbor term
  task automatic leaky_relu_scores();
    load_identity_w();
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      write_weight(A_SRC_BASE + k, -3);
      write_weight(A_NBR_BASE + k, 1);
    end
    add_node({8'd4, 8'd3, 8'd2, 8'd1}, 1'b1);
    add_node({8'd2, 8'd2, 8'd2, 8'd2}, 1'b0);
    add_node({8'd5, 8'd0, 8'd1, 8'd0}, 1'b0);
    run_nodes(0);
  endtask

  task automatic random_subgraphs();
    int sizes [3];
    sizes = '{3, 1, 5};
    for (int a = 0; a < WGT_DEPTH; a++) begin
      write_weight(a, int'(rand_bits(DATA_W)));
    end
    foreach (sizes[s]) begin
      for (int n = 0; n < sizes[s]; n++) begin
        add_node(feat_vec_t'(rand_bits(32)), n == 0);
      end
    end
    run_nodes(0);
  endtask

  task automatic backpressure_order();
    max_ack_wait = 0;
    for (int n = 0; n < 10; n++) begin
      add_node(feat_vec_t'(rand_bits(32)), n == 0 || n == 4);
    end
    // Ack held off 0 to 15 cycles per score
    run_nodes(4);
    // Two cycles is the unstalled wait for in_ack
    if (max_ack_wait <= 2) begin
      err_count++;
      $display("in_ack never waited while the pipeline was full");
    end
    for (int c = 0; c < 8; c++) begin
      @(posedge clk);
      #1;
      if (out_req !== 1'b0) begin
        err_count++;
        $display("Fail out_req expected %h got %h", 1'b0, out_req);
      end
    end
  endtask

  // ====================
  initial begin
    err_count     = 0;
    timeout_count = 0;
    max_ack_wait  = 0;
    ack_cycle     = 0;
    req_cycle     = 0;
    lfsr_state    = 16'd65;
    ref_src_score = 0;
    foreach (ref_wgt[a]) begin
      ref_wgt[a] = 0;
    end
    rst_n       = 1'b0;
    wgt_wr_en   = 1'b0;
    wgt_wr_addr = '0;
    wgt_wr_data = '0;
    in_req      = 1'b0;
    in_feat     = '0;
    in_src      = 1'b0;
    out_ack     = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    reset_state_scores();
    identity_scores();
    leaky_relu_scores();
    random_subgraphs();
    backpressure_order();

    $display("Errors: %0d mismatches, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== src/gat_core.sv ====
`timescale 1ns/1ps
// Attention layer core, weight memory and the four-stage chain

module gat_core
  import gat_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // Weight port
  input  logic                  wgt_wr_en,
  input  logic [WGT_ADDR_W-1:0] wgt_wr_addr,
  input  logic [DATA_W-1:0]     wgt_wr_data,
  // Input handshake
  input  logic                  in_req,
  input  feat_vec_t             in_feat,
  input  logic                  in_src,
  output logic                  in_ack,
  // Output handshake
  output logic                  out_req,
  output logic [COEF_W-1:0]     out_coef,
  output logic                  out_src,
  input  logic                  out_ack
);

  wgt_flat_t                wgt_flat;
  logic                     feat_valid;
  feat_vec_t                feat;
  logic                     feat_src;
  logic                     feat_hold;
  logic                     wh_valid;
  wh_vec_t                  wh;
  logic                     wh_src;
  logic                     wh_hold;
  logic                     coef_valid;
  logic signed [COEF_W-1:0] coef;
  logic                     coef_src;
  logic                     coef_hold;

  // ====================
  weight_mem u_weight_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_wr_en   (wgt_wr_en),
    .wgt_wr_addr (wgt_wr_addr),
    .wgt_wr_data (wgt_wr_data),
    .wgt_flat    (wgt_flat)
  );

  // ====================
  feat_rx u_feat_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req     (in_req),
    .in_feat    (in_feat),
    .in_src     (in_src),
    .in_ack     (in_ack),
    .feat_valid (feat_valid),
    .feat       (feat),
    .feat_src   (feat_src),
    .feat_hold  (feat_hold)
  );

  wh_mult u_wh_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .feat_valid (feat_valid),
    .feat       (feat),
    .feat_src   (feat_src),
    .feat_hold  (feat_hold),
    .wgt_flat   (wgt_flat),
    .wh_valid   (wh_valid),
    .wh         (wh),
    .wh_src     (wh_src),
    .wh_hold    (wh_hold)
  );

  attn_coef u_attn_coef (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_valid   (wh_valid),
    .wh         (wh),
    .wh_src     (wh_src),
    .wh_hold    (wh_hold),
    .wgt_flat   (wgt_flat),
    .coef_valid (coef_valid),
    .coef       (coef),
    .coef_src   (coef_src),
    .coef_hold  (coef_hold)
  );

  coef_tx u_coef_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .coef_valid (coef_valid),
    .coef       (coef),
    .coef_src   (coef_src),
    .coef_hold  (coef_hold),
    .out_req    (out_req),
    .out_coef   (out_coef),
    .out_src    (out_src),
    .out_ack    (out_ack)
  );

endmodule

// ==== src/coef_tx.sv ====
`timescale 1ns/1ps
// Four-phase sender for attention scores

module coef_tx
  import gat_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     coef_valid,
  input  logic signed [COEF_W-1:0] coef,
  input  logic                     coef_src,
  output logic                     coef_hold,
  output logic                     out_req,
  output logic [COEF_W-1:0]        out_coef,
  output logic                     out_src,
  input  logic                     out_ack
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_ARM,
    TX_REQ,
    TX_REL
  } tx_state_t;

  tx_state_t state;
  logic      take;

  // Busy from capture until ack has fallen
  assign coef_hold = (state != TX_IDLE) && !(state == TX_REL && !out_ack);
  assign take      = coef_valid && !coef_hold;
  assign out_req   = (state == TX_REQ);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= TX_IDLE;
    end else begin
      case (state)
        TX_IDLE: begin
          if (take) begin
            state <= TX_ARM;
          end
        end
        TX_ARM: state <= TX_REQ;
        TX_REQ: begin
          if (out_ack) begin
            state <= TX_REL;
          end
        end
        default: begin
          // Next score may be taken as the ack falls
          if (!out_ack) begin
            state <= take ? TX_ARM : TX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_coef <= coef;
      out_src  <= coef_src;
    end
  end

endmodule

// ==== src/attn_coef.sv ====
`timescale 1ns/1ps
// Attention score stage with the stored source score
// LeakyReLU by arithmetic shift on negative sums

module attn_coef
  import gat_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wh_valid,
  input  wh_vec_t                  wh,
  input  logic                     wh_src,
  output logic                     wh_hold,
  input  wgt_flat_t                wgt_flat,
  output logic                     coef_valid,
  output logic signed [COEF_W-1:0] coef,
  output logic                     coef_src,
  input  logic                     coef_hold
);

  logic signed [COEF_W-1:0] src_dot;
  logic signed [COEF_W-1:0] nbr_dot;
  logic signed [COEF_W-1:0] src_score;
  logic signed [COEF_W-1:0] base_score;
  logic signed [COEF_W-1:0] raw_score;
  logic signed [COEF_W-1:0] lrelu_score;
  logic                     load;

  assign wh_hold = coef_valid && coef_hold;
  assign load    = wh_valid && !wh_hold;

  // ====================
  // a_src and a_nbr halves against Wh
  always_comb begin : attn_dot
    logic signed [COEF_W-1:0] src_acc;
    logic signed [COEF_W-1:0] nbr_acc;
    src_acc = '0;
    nbr_acc = '0;
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      src_acc = src_acc + $signed(wgt_flat[A_SRC_BASE+k]) * $signed(wh[k]);
      nbr_acc = nbr_acc + $signed(wgt_flat[A_NBR_BASE+k]) * $signed(wh[k]);
    end
    src_dot = src_acc;
    nbr_dot = nbr_acc;
  end

  // Source node uses its own fresh score
  assign base_score  = wh_src ? src_dot : src_score;
  assign raw_score   = base_score + nbr_dot;
  assign lrelu_score = raw_score[COEF_W-1] ? (raw_score >>> LRELU_SHIFT) : raw_score;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      src_score <= '0;
    end else if (load && wh_src) begin
      src_score <= src_dot;
    end
  end

  // ====================
  // Stage register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      coef_valid <= 1'b0;
    end else if (load) begin
      coef_valid <= 1'b1;
    end else if (!coef_hold) begin
      coef_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      coef     <= lrelu_score;
      coef_src <= wh_src;
    end
  end

endmodule

// ==== src/wh_mult.sv ====
`timescale 1ns/1ps
// Wh stage, multiplies the node vector by W
// All output features computed in one cycle and registered

module wh_mult
  import gat_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      feat_valid,
  input  feat_vec_t feat,
  input  logic      feat_src,
  output logic      feat_hold,
  input  wgt_flat_t wgt_flat,
  output logic      wh_valid,
  output wh_vec_t   wh,
  output logic      wh_src,
  input  logic      wh_hold
);

  wh_vec_t wh_next;
  logic    load;

  // Full and blocked downstream
  assign feat_hold = wh_valid && wh_hold;
  assign load      = feat_valid && !feat_hold;

  // ====================
  // Dot products with W rows
  always_comb begin : dot_prod
    logic signed [WH_W-1:0] acc;
    for (int k = 0; k < NUM_FEAT_OUT; k++) begin
      acc = '0;
      for (int i = 0; i < NUM_FEAT_IN; i++) begin
        // Row k, column i
        acc = acc + $signed(feat[i]) * $signed(wgt_flat[k*NUM_FEAT_IN+i]);
      end
      wh_next[k] = acc;
    end
  end

  // ====================
  // Stage register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wh_valid <= 1'b0;
    end else if (load) begin
      wh_valid <= 1'b1;
    end else if (!wh_hold) begin
      wh_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      wh     <= wh_next;
      wh_src <= feat_src;
    end
  end

endmodule

// ==== src/feat_rx.sv ====
`timescale 1ns/1ps
// Four-phase receiver for node feature vectors
// One-item buffer feeding the Wh stage

module feat_rx
  import gat_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_req,
  input  feat_vec_t in_feat,
  input  logic      in_src,
  output logic      in_ack,
  output logic      feat_valid,
  output feat_vec_t feat,
  output logic      feat_src,
  input  logic      feat_hold
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT,
    RX_ACK,
    RX_REL
  } rx_state_t;

  rx_state_t state;
  logic      buf_free;
  logic      capture;

  // Buffer is free if empty or its item leaves this cycle
  assign buf_free = !feat_valid || !feat_hold;
  assign capture  = in_req && buf_free && (state == RX_IDLE || state == RX_WAIT);
  assign in_ack   = (state == RX_ACK);

  // ====================
  // Handshake FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= RX_IDLE;
    end else begin
      case (state)
        RX_IDLE: begin
          if (capture) begin
            state <= RX_ACK;
          end else if (in_req) begin
            state <= RX_WAIT;
          end
        end
        RX_WAIT: begin
          if (capture) begin
            state <= RX_ACK;
          end
        end
        RX_ACK: begin
          if (!in_req) begin
            state <= RX_REL;
          end
        end
        // Ack is low again, return to zero
        default: state <= RX_IDLE;
      endcase
    end
  end

  // ====================
  // Item buffer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      feat_valid <= 1'b0;
    end else if (capture) begin
      feat_valid <= 1'b1;
    end else if (!feat_hold) begin
      feat_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      feat     <= in_feat;
      feat_src <= in_src;
    end
  end

endmodule

// ==== src/weight_mem.sv ====
`timescale 1ns/1ps
// Register memory for W and a
// One entry written per cycle, every entry visible in parallel

module weight_mem
  import gat_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wgt_wr_en,
  input  logic [WGT_ADDR_W-1:0] wgt_wr_addr,
  input  logic [DATA_W-1:0]     wgt_wr_data,
  output wgt_flat_t             wgt_flat
);

  logic [WGT_DEPTH-1:0] entry_sel;

  // Address decode, writes past the last entry are dropped
  always_comb begin
    for (int e = 0; e < WGT_DEPTH; e++) begin
      entry_sel[e] = wgt_wr_en && (wgt_wr_addr == WGT_ADDR_W'(e));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wgt_flat <= '0;
    end else begin
      for (int e = 0; e < WGT_DEPTH; e++) begin
        if (entry_sel[e]) begin
          wgt_flat[e] <= wgt_wr_data;
        end
      end
    end
  end

endmodule

// ==== src/gat_pkg.sv ====
// Sizes, widths and packed vector types of the attention layer
// Weight memory layout offsets for the a_src and a_nbr halves

package gat_pkg;

  // ====================
  // Layer sizes
  localparam int DATA_W       = 8;
  localparam int NUM_FEAT_IN  = 4;
  localparam int NUM_FEAT_OUT = 4;

  // ====================
  // Weight memory layout
  localparam int W_DEPTH    = NUM_FEAT_IN * NUM_FEAT_OUT;
  localparam int A_DEPTH    = 2 * NUM_FEAT_OUT;
  localparam int WGT_DEPTH  = W_DEPTH + A_DEPTH;
  localparam int WGT_ADDR_W = $clog2(WGT_DEPTH);

  // a_src sits right after W, a_nbr after a_src
  localparam int A_SRC_BASE = W_DEPTH;
  localparam int A_NBR_BASE = W_DEPTH + NUM_FEAT_OUT;

  // ====================
  // Datapath widths
  // 8x8 product plus two bits of growth for a 4-term sum
  localparam int WH_W        = 18;
  localparam int COEF_W      = 32;
  localparam int LRELU_SHIFT = 3;

  // Elements are two's complement, sliced with $signed where used
  typedef logic [NUM_FEAT_IN-1:0][DATA_W-1:0] feat_vec_t;
  typedef logic [NUM_FEAT_OUT-1:0][WH_W-1:0]  wh_vec_t;
  typedef logic [WGT_DEPTH-1:0][DATA_W-1:0]   wgt_flat_t;

endpackage
